// ==== src/txdp_pkg.sv ====
`default_nettype none

package txdp_pkg;

  //********************************************************************
  // Datapath sizing
  //********************************************************************

  // Output word width; data_in carries two of these
  localparam int txdp_dwidth = 40;

  // Threshold ports at the top level
  localparam int txdp_cfg_awidth = 5;

  // Internal FIFO address, 16 entries
  localparam int txdp_fifo_awidth = 4;
  localparam int txdp_fifo_depth = 1 << txdp_fifo_awidth;  // Entry count

  // Output value out of reset and on idle read cycles
  localparam logic [txdp_dwidth-1:0] txdp_data_default = '0;

  //********************************************************************
  // Phase-comp controls
  //********************************************************************

  // Codes above this fall back to the 2-cycle tap
  localparam logic [2:0] txdp_rd_delay_max = 3'd6;

  // FIFO operating mode
  typedef enum logic [1:0] {
    mode_phcomp_1x = 2'b00,  // Traffic, direct_data source
    mode_phcomp_2x = 2'b01,  // Traffic, data_in low half
    mode_reserved  = 2'b10,  // Idle, not ready
    mode_register  = 2'b11   // Idle, ready
  } fifo_mode_e;

endpackage

`default_nettype wire

// ==== src/txdp_bitsync.sv ====
`timescale 1ns/10ps
`default_nettype none

// Two-flop level synchronizer, clears to 0
module txdp_bitsync (
  input  logic clk,       // Destination clock
  input  logic rd_rst_n,  // Destination domain reset
  input  logic data_in,   // Async level
  output logic data_out   // Synchronized level
);

  logic sync_meta;  // First stage, may go metastable

  always_ff @(posedge clk) begin
    if (!rd_rst_n) begin
      sync_meta <= 1'b0;
      data_out  <= 1'b0;
    end else begin
      sync_meta <= data_in;    // Capture
      data_out  <= sync_meta;  // Settle
    end
  end

endmodule

`default_nettype wire

// ==== src/txdp_async_fifo.sv ====
`timescale 1ns/10ps
`default_nettype none

// Dual-clock FIFO with gray pointer crossing and threshold flags
module txdp_async_fifo (
  input  logic                                    wr_clk,       // Write clock
  input  logic                                    wr_rst_n,     // Write reset
  input  logic                                    wr_en,        // Push request
  input  logic [txdp_pkg::txdp_dwidth-1:0]        wr_data,      // Push word
  input  logic                                    rd_clk,       // Read clock
  input  logic                                    rd_rst_n,     // Read reset
  input  logic                                    rd_en,        // Pop request
  input  logic [txdp_pkg::txdp_fifo_awidth-1:0]   r_empty,      // Empty threshold
  input  logic [txdp_pkg::txdp_fifo_awidth-1:0]   r_pempty,     // Partial empty threshold
  input  logic [txdp_pkg::txdp_fifo_awidth-1:0]   r_full,       // Full threshold
  input  logic [txdp_pkg::txdp_fifo_awidth-1:0]   r_pfull,      // Partial full threshold
  output logic [txdp_pkg::txdp_dwidth-1:0]        rd_data,      // Head word
  output logic                                    wr_full,      // Write domain flags
  output logic                                    wr_pfull,
  output logic                                    rd_empty,     // Read domain flags
  output logic                                    rd_pempty,
  output logic                                    wr_addr_msb,  // Latency observation
  output logic                                    rd_addr_msb
);

  logic [txdp_pkg::txdp_dwidth-1:0] mem [txdp_pkg::txdp_fifo_depth];  // Storage, no reset

  // Pointers carry one wrap bit above the address
  logic [txdp_pkg::txdp_fifo_awidth:0] wr_bin, wr_bin_next, wr_gray;
  logic [txdp_pkg::txdp_fifo_awidth:0] rd_bin, rd_bin_next, rd_gray;
  logic [txdp_pkg::txdp_fifo_awidth:0] rd_gray_wsync1, rd_gray_wsync2;  // Read ptr in wr_clk
  logic [txdp_pkg::txdp_fifo_awidth:0] wr_gray_rsync1, wr_gray_rsync2;  // Write ptr in rd_clk
  logic [txdp_pkg::txdp_fifo_awidth:0] wr_level, rd_level;              // Occupancy per domain
  logic                                wr_push, rd_pop;

  function automatic logic [txdp_pkg::txdp_fifo_awidth:0] gray2bin(
    input logic [txdp_pkg::txdp_fifo_awidth:0] gray
  );
    logic [txdp_pkg::txdp_fifo_awidth:0] bin;
    bin[txdp_pkg::txdp_fifo_awidth] = gray[txdp_pkg::txdp_fifo_awidth];
    for (int i = txdp_pkg::txdp_fifo_awidth - 1; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i];  // Prefix XOR from the top
    end
    return bin;
  endfunction

  //********************************************************************
  // Write domain
  //********************************************************************

  assign wr_level    = wr_bin - gray2bin(rd_gray_wsync2);      // Conservative occupancy
  assign wr_push     = wr_en && !wr_level[txdp_pkg::txdp_fifo_awidth];  // Drop when 16 held
  assign wr_bin_next = wr_bin + {{txdp_pkg::txdp_fifo_awidth{1'b0}}, wr_push};

  always_ff @(posedge wr_clk) begin
    if (!wr_rst_n) begin
      wr_bin         <= '0;
      wr_gray        <= '0;
      rd_gray_wsync1 <= '0;
      rd_gray_wsync2 <= '0;
    end else begin
      wr_bin         <= wr_bin_next;
      wr_gray        <= wr_bin_next ^ (wr_bin_next >> 1);  // Binary to gray
      rd_gray_wsync1 <= rd_gray;         // Cross from rd_clk
      rd_gray_wsync2 <= rd_gray_wsync1;
    end
  end

  always_ff @(posedge wr_clk) begin
    if (wr_push) begin
      mem[wr_bin[txdp_pkg::txdp_fifo_awidth-1:0]] <= wr_data;
    end
  end

  assign wr_full     = wr_level >= {1'b0, r_full};   // At or above threshold
  assign wr_pfull    = wr_level >= {1'b0, r_pfull};
  assign wr_addr_msb = wr_bin[txdp_pkg::txdp_fifo_awidth-1];

  //********************************************************************
  // Read domain
  //********************************************************************

  assign rd_level    = gray2bin(wr_gray_rsync2) - rd_bin;
  assign rd_pop      = rd_en && (rd_level != '0);   // No advance when empty
  assign rd_bin_next = rd_bin + {{txdp_pkg::txdp_fifo_awidth{1'b0}}, rd_pop};
  assign rd_data     = mem[rd_bin[txdp_pkg::txdp_fifo_awidth-1:0]];  // Head, unregistered

  always_ff @(posedge rd_clk) begin
    if (!rd_rst_n) begin
      rd_bin         <= '0;
      rd_gray        <= '0;
      wr_gray_rsync1 <= '0;
      wr_gray_rsync2 <= '0;
    end else begin
      rd_bin         <= rd_bin_next;
      rd_gray        <= rd_bin_next ^ (rd_bin_next >> 1);
      wr_gray_rsync1 <= wr_gray;         // Cross from wr_clk
      wr_gray_rsync2 <= wr_gray_rsync1;
    end
  end

  assign rd_empty    = rd_level <= {1'b0, r_empty};  // At or below threshold
  assign rd_pempty   = rd_level <= {1'b0, r_pempty};
  assign rd_addr_msb = rd_bin[txdp_pkg::txdp_fifo_awidth-1];

endmodule

`default_nettype wire

// ==== src/txdp_phcomp_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

// Phase-comp enable generation and latency adjust
module txdp_phcomp_ctrl (
  input  logic                 wr_clk,             // Write clock
  input  logic                 wr_rst_n,           // Write reset
  input  logic                 rd_clk,             // Read clock
  input  logic                 rd_rst_n,           // Read reset
  input  txdp_pkg::fifo_mode_e r_fifo_mode,        // Operating mode
  input  logic [2:0]           r_phcomp_rd_delay,  // Read delay code
  input  logic                 r_wr_adj_en,        // Allow write removal
  input  logic                 r_rd_adj_en,        // Allow read removal
  input  logic                 fifo_latency_adj,   // Async level, edge acts
  output logic                 phcomp_wren,        // Write enable ramp
  output logic                 phcomp_rden,        // Delayed read enable
  output logic                 wr_en,              // FIFO push
  output logic                 rd_en,              // FIFO pop
  output logic                 phcomp_mode,        // Traffic modes
  output logic                 wdata_sel_direct,   // Use direct_data
  output logic                 fifo_ready          // Register mode
);

  logic       phcomp_wren_d0, phcomp_wren_d1, phcomp_wren_d2;  // Write ramp
  logic       phcomp_wren_sync2;      // Ramp in rd_clk
  logic [6:3] phcomp_wren_dly;        // Extra delay taps
  logic [2:0] rd_delay_code;          // Clamped code
  logic       adj_wr_sync, adj_wr_sync_d0, adj_wr_pulse;
  logic       adj_rd_sync, adj_rd_sync_d0, adj_rd_pulse;

  //********************************************************************
  // Mode decode
  //********************************************************************

  assign phcomp_mode      = (r_fifo_mode == txdp_pkg::mode_phcomp_1x) ||
                            (r_fifo_mode == txdp_pkg::mode_phcomp_2x);
  assign wdata_sel_direct = (r_fifo_mode == txdp_pkg::mode_phcomp_1x);
  assign fifo_ready       = (r_fifo_mode == txdp_pkg::mode_register);  // Reserved stays low

  //********************************************************************
  // Write enable ramp, high on third edge after reset
  //********************************************************************

  always_ff @(posedge wr_clk) begin
    if (!wr_rst_n) begin
      phcomp_wren_d0 <= 1'b0;
      phcomp_wren_d1 <= 1'b0;
      phcomp_wren_d2 <= 1'b0;
    end else begin
      phcomp_wren_d0 <= 1'b1;            // Sticks high
      phcomp_wren_d1 <= phcomp_wren_d0;
      phcomp_wren_d2 <= phcomp_wren_d1;
    end
  end

  assign phcomp_wren = phcomp_wren_d2;

  // Ramp into read domain, 2 cycles
  txdp_bitsync u_sync_wren (
    .clk      (rd_clk),
    .rd_rst_n (rd_rst_n),
    .data_in  (phcomp_wren),
    .data_out (phcomp_wren_sync2)
  );

  always_ff @(posedge rd_clk) begin
    if (!rd_rst_n) begin
      phcomp_wren_dly <= '0;
    end else begin
      phcomp_wren_dly <= {phcomp_wren_dly[5:3], phcomp_wren_sync2};  // Taps 3..6
    end
  end

  // Codes 0-2 and 7 all take the synchronizer output
  assign rd_delay_code = (r_phcomp_rd_delay > txdp_pkg::txdp_rd_delay_max) ?
                         3'd0 : r_phcomp_rd_delay;

  always_comb begin
    if (rd_delay_code >= 3'd3) begin
      phcomp_rden = phcomp_wren_dly[rd_delay_code];
    end else begin
      phcomp_rden = phcomp_wren_sync2;
    end
  end

  //********************************************************************
  // Latency adjust, one removed beat per rising edge
  //********************************************************************

  txdp_bitsync u_sync_adj_wr (
    .clk      (wr_clk),
    .rd_rst_n (wr_rst_n),
    .data_in  (fifo_latency_adj),
    .data_out (adj_wr_sync)
  );

  txdp_bitsync u_sync_adj_rd (
    .clk      (rd_clk),
    .rd_rst_n (rd_rst_n),
    .data_in  (fifo_latency_adj),
    .data_out (adj_rd_sync)
  );

  always_ff @(posedge wr_clk) begin
    if (!wr_rst_n) begin
      adj_wr_sync_d0 <= 1'b0;
    end else begin
      adj_wr_sync_d0 <= adj_wr_sync;  // Edge history
    end
  end

  always_ff @(posedge rd_clk) begin
    if (!rd_rst_n) begin
      adj_rd_sync_d0 <= 1'b0;
    end else begin
      adj_rd_sync_d0 <= adj_rd_sync;
    end
  end

  assign adj_wr_pulse = r_wr_adj_en && adj_wr_sync && !adj_wr_sync_d0;
  assign adj_rd_pulse = r_rd_adj_en && adj_rd_sync && !adj_rd_sync_d0;

  assign wr_en = phcomp_mode && phcomp_wren && !adj_wr_pulse;  // Masked push
  assign rd_en = phcomp_mode && phcomp_rden && !adj_rd_pulse;  // Masked pop

endmodule

`default_nettype wire

// ==== src/txdp_out_reg.sv ====
`timescale 1ns/10ps
`default_nettype none

// Read-domain output register and testbus packing
module txdp_out_reg (
  input  logic                             rd_clk,            // Read clock
  input  logic                             rd_rst_n,          // Read reset
  input  logic                             phcomp_mode,       // Traffic modes
  input  logic                             rd_en,             // Pop this cycle
  input  logic [txdp_pkg::txdp_dwidth-1:0] rd_data,           // FIFO head
  input  logic                             wr_en,             // Write side status
  input  logic                             wr_full,
  input  logic                             wr_pfull,
  input  logic                             wr_addr_msb,
  input  logic                             rd_empty,          // Read side status
  input  logic                             rd_pempty,
  input  logic                             rd_addr_msb,
  output logic [txdp_pkg::txdp_dwidth-1:0] data_out,          // Registered word
  output logic [19:0]                      tx_fifo_testbus1,  // Write side bus
  output logic [19:0]                      tx_fifo_testbus2   // Read side bus
);

  always_ff @(posedge rd_clk) begin
    if (!rd_rst_n) begin
      data_out <= txdp_pkg::txdp_data_default;
    end else if (phcomp_mode && !rd_en) begin
      data_out <= txdp_pkg::txdp_data_default;  // Idle beat reads as zero
    end else if (rd_en) begin
      data_out <= rd_data;                      // Capture popped word
    end
  end

  // Status in low nibble, enable at bit 0
  assign tx_fifo_testbus1 = {16'd0, wr_full, wr_pfull, wr_addr_msb, wr_en};
  assign tx_fifo_testbus2 = {16'd0, rd_empty, rd_pempty, rd_addr_msb, rd_en};

endmodule

`default_nettype wire

// ==== src/aib_adapttxdp_fifo.sv ====
`timescale 1ns/10ps
`default_nettype none

// Transmit datapath FIFO, phase-comp and register modes
module aib_adapttxdp_fifo (
  input  logic                                 wr_clk,               // Write clock
  input  logic                                 wr_rst_n,             // Write reset
  input  logic [2*txdp_pkg::txdp_dwidth-1:0]   data_in,              // Only low half used
  input  logic [txdp_pkg::txdp_dwidth-1:0]     direct_data,          // Mode 00 source
  input  logic                                 rd_clk,               // Read clock
  input  logic                                 rd_rst_n,             // Read reset
  input  logic [txdp_pkg::txdp_cfg_awidth-1:0] r_pempty,             // Thresholds
  input  logic [txdp_pkg::txdp_cfg_awidth-1:0] r_pfull,
  input  logic [txdp_pkg::txdp_cfg_awidth-1:0] r_empty,
  input  logic [txdp_pkg::txdp_cfg_awidth-1:0] r_full,
  input  txdp_pkg::fifo_mode_e                 r_fifo_mode,          // Operating mode
  input  logic [2:0]                           r_phcomp_rd_delay,    // Read delay code
  input  logic                                 r_wr_adj_en,
  input  logic                                 r_rd_adj_en,
  input  logic                                 fifo_latency_adj,
  output logic [txdp_pkg::txdp_dwidth-1:0]     aib_hssi_tx_data_out, // Registered output
  output logic [19:0]                          tx_fifo_testbus1,
  output logic [19:0]                          tx_fifo_testbus2,
  output logic                                 fifo_ready,
  output logic                                 fifo_empty,
  output logic                                 fifo_pempty,
  output logic                                 fifo_pfull,
  output logic                                 fifo_full,
  output logic                                 phcomp_wren,          // To bonding
  output logic                                 phcomp_rden
);

  logic                             wr_en, rd_en, phcomp_mode, wdata_sel_direct;
  logic [txdp_pkg::txdp_dwidth-1:0] wr_data, rd_data;
  logic                             wr_addr_msb, rd_addr_msb;

  // Write source mux
  assign wr_data = wdata_sel_direct ? direct_data : data_in[txdp_pkg::txdp_dwidth-1:0];

  txdp_phcomp_ctrl u_ctrl (
    .wr_clk            (wr_clk),
    .wr_rst_n          (wr_rst_n),
    .rd_clk            (rd_clk),
    .rd_rst_n          (rd_rst_n),
    .r_fifo_mode       (r_fifo_mode),
    .r_phcomp_rd_delay (r_phcomp_rd_delay),
    .r_wr_adj_en       (r_wr_adj_en),
    .r_rd_adj_en       (r_rd_adj_en),
    .fifo_latency_adj  (fifo_latency_adj),
    .phcomp_wren       (phcomp_wren),
    .phcomp_rden       (phcomp_rden),
    .wr_en             (wr_en),
    .rd_en             (rd_en),
    .phcomp_mode       (phcomp_mode),
    .wdata_sel_direct  (wdata_sel_direct),
    .fifo_ready        (fifo_ready)
  );

  txdp_async_fifo u_fifo (
    .wr_clk      (wr_clk),
    .wr_rst_n    (wr_rst_n),
    .wr_en       (wr_en),
    .wr_data     (wr_data),
    .rd_clk      (rd_clk),
    .rd_rst_n    (rd_rst_n),
    .rd_en       (rd_en),
    .r_empty     (r_empty[txdp_pkg::txdp_fifo_awidth-1:0]),   // Low bits only
    .r_pempty    (r_pempty[txdp_pkg::txdp_fifo_awidth-1:0]),
    .r_full      (r_full[txdp_pkg::txdp_fifo_awidth-1:0]),
    .r_pfull     (r_pfull[txdp_pkg::txdp_fifo_awidth-1:0]),
    .rd_data     (rd_data),
    .wr_full     (fifo_full),
    .wr_pfull    (fifo_pfull),
    .rd_empty    (fifo_empty),
    .rd_pempty   (fifo_pempty),
    .wr_addr_msb (wr_addr_msb),
    .rd_addr_msb (rd_addr_msb)
  );

  txdp_out_reg u_out_reg (
    .rd_clk           (rd_clk),
    .rd_rst_n         (rd_rst_n),
    .phcomp_mode      (phcomp_mode),
    .rd_en            (rd_en),
    .rd_data          (rd_data),
    .wr_en            (wr_en),
    .wr_full          (fifo_full),
    .wr_pfull         (fifo_pfull),
    .wr_addr_msb      (wr_addr_msb),
    .rd_empty         (fifo_empty),
    .rd_pempty        (fifo_pempty),
    .rd_addr_msb      (rd_addr_msb),
    .data_out         (aib_hssi_tx_data_out),
    .tx_fifo_testbus1 (tx_fifo_testbus1),
    .tx_fifo_testbus2 (tx_fifo_testbus2)
  );

endmodule

`default_nettype wire

// ==== bench/txdp_asserts.sv ====
`timescale 1ns/10ps
`default_nettype none

// Enable timing checks for the phase-comp controller
module txdp_asserts (
  input logic       wr_clk,
  input logic       wr_rst_n,
  input logic       rd_clk,
  input logic       rd_rst_n,
  input logic [2:0] r_phcomp_rd_delay,
  input logic       phcomp_wren,
  input logic       phcomp_rden,
  input logic       wr_en,
  input logic       rd_en
);

  int fail_count = 0;  // Failed assertion count

  // Read enable lag behind the write ramp, in rd_clk edges
  function automatic int rden_lag(input int code);
    return (code >= 3 && code <= 6) ? code : 2;  // Out-of-range codes take the sync tap
  endfunction

  wr_reset_low: assert property (@(posedge wr_clk) !wr_rst_n |=> !phcomp_wren && !wr_en)
    else begin
      $error("write enables active after a reset edge");
      fail_count++;
    end

  rd_reset_low: assert property (@(posedge rd_clk) !rd_rst_n |=> !phcomp_rden && !rd_en)
    else begin
      $error("read enables active after a reset edge");
      fail_count++;
    end

  // Ramp goes high on the third edge after release
  wren_ramp: assert property (@(posedge wr_clk) disable iff (!wr_rst_n)
      $rose(wr_rst_n) |-> !phcomp_wren [*3] ##1 phcomp_wren)
    else begin
      $error("phcomp_wren did not rise on the third edge after reset");
      fail_count++;
    end

  wren_hold: assert property (@(posedge wr_clk) disable iff (!wr_rst_n)
      phcomp_wren |=> phcomp_wren)
    else begin
      $error("phcomp_wren dropped");
      fail_count++;
    end

  rden_hold: assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
      phcomp_rden |=> phcomp_rden)
    else begin
      $error("phcomp_rden dropped");
      fail_count++;
    end

  for (genvar c = 0; c < 8; c++) begin : g_rden_lag
    localparam int lag = rden_lag(c);
    rden_rise: assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
        (r_phcomp_rd_delay == c) && $rose(phcomp_wren) |-> !phcomp_rden [*lag] ##1 phcomp_rden)
      else begin
        $error("phcomp_rden lag wrong for delay code %0d", c);
        fail_count++;
      end
  end

endmodule

bind txdp_phcomp_ctrl txdp_asserts u_asserts (
  .wr_clk            (wr_clk),
  .wr_rst_n          (wr_rst_n),
  .rd_clk            (rd_clk),
  .rd_rst_n          (rd_rst_n),
  .r_phcomp_rd_delay (r_phcomp_rd_delay),
  .phcomp_wren       (phcomp_wren),
  .phcomp_rden       (phcomp_rden),
  .wr_en             (wr_en),
  .rd_en             (rd_en)
);

`default_nettype wire

// ==== bench/tb_txdp.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_txdp;

  localparam int cycle_limit = 1500;  // About 450 cycles of tests plus margin

  logic                                 clk;
  logic                                 rst_n;             // Drives both domain resets
  logic [2*txdp_pkg::txdp_dwidth-1:0]   data_in;
  logic [txdp_pkg::txdp_dwidth-1:0]     direct_data;
  logic [txdp_pkg::txdp_dwidth-1:0]     data_out;
  logic [txdp_pkg::txdp_cfg_awidth-1:0] r_pempty, r_pfull, r_empty, r_full;
  txdp_pkg::fifo_mode_e                 r_fifo_mode;
  logic [2:0]                           r_phcomp_rd_delay;
  logic                                 r_wr_adj_en, r_rd_adj_en, fifo_latency_adj;
  logic [19:0]                          tx_fifo_testbus1, tx_fifo_testbus2;
  logic                                 fifo_ready, fifo_empty, fifo_pempty;
  logic                                 fifo_pfull, fifo_full, phcomp_wren, phcomp_rden;

  logic [31:0]                      lfsr;     // Stimulus LFSR state
  logic [txdp_pkg::txdp_dwidth-1:0] ref_q[$]; // Written words, oldest first
  int cycle_count = 0;
  int error_count = 0;
  int check_count = 0;
  int test_count = 0;
  int errors_marked = 0;
  int words_seen, zero_beats;

  aib_adapttxdp_fifo uut (
    .wr_clk (clk), .wr_rst_n (rst_n), .data_in (data_in), .direct_data (direct_data),
    .rd_clk (clk), .rd_rst_n (rst_n),
    .r_pempty (r_pempty), .r_pfull (r_pfull), .r_empty (r_empty), .r_full (r_full),
    .r_fifo_mode (r_fifo_mode), .r_phcomp_rd_delay (r_phcomp_rd_delay),
    .r_wr_adj_en (r_wr_adj_en), .r_rd_adj_en (r_rd_adj_en),
    .fifo_latency_adj (fifo_latency_adj), .aib_hssi_tx_data_out (data_out),
    .tx_fifo_testbus1 (tx_fifo_testbus1), .tx_fifo_testbus2 (tx_fifo_testbus2),
    .fifo_ready (fifo_ready), .fifo_empty (fifo_empty), .fifo_pempty (fifo_pempty),
    .fifo_pfull (fifo_pfull), .fifo_full (fifo_full),
    .phcomp_wren (phcomp_wren), .phcomp_rden (phcomp_rden)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // 4 ns, one source for both domains
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("Run stopped: %0d cycles passed and the tests had not finished", cycle_limit);
      $display("Verification failed");
      $finish;
    end
  end

  //**********************************************************************
  // Helpers
  //**********************************************************************

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);  // Galois, right shift
  endfunction

  task automatic next_word(output logic [txdp_pkg::txdp_dwidth-1:0] w);
    for (int i = 0; i < txdp_pkg::txdp_dwidth; i++) begin
      w[i] = lfsr[0];  // Never 32 zeros in a row, so never a zero word
      lfsr = lfsr_step(lfsr);
    end
  endtask

  task automatic check_value(input logic ok, input string msg);
    check_count++;
    assert (ok === 1'b1) else begin
      $display("FAIL %0t: %s", $time, msg);
      error_count++;
    end
  endtask

  task automatic check_reset_state();
    check_value(!fifo_full && !fifo_pfull && fifo_empty && fifo_pempty,
                "flags not in reset state");
    check_value(!phcomp_wren && !phcomp_rden, "enables high in reset");
    check_value(data_out == txdp_pkg::txdp_data_default, "output not cleared by reset");
  endtask

  task automatic apply_reset(input txdp_pkg::fifo_mode_e mode, input logic [2:0] code,
                             input logic wr_adj, input logic rd_adj, input logic [4:0] pfull);
    rst_n = 1'b0;
    r_fifo_mode = mode;
    r_phcomp_rd_delay = code;
    r_wr_adj_en = wr_adj;
    r_rd_adj_en = rd_adj;
    r_pfull = pfull;
    fifo_latency_adj = 1'b0;
    ref_q.delete();
    repeat (10) begin
      @(posedge clk);
      #0.5;
      check_reset_state();
    end
    rst_n = 1'b1;
  endtask

  // One pass of n cycles after release; adj_at < 0 means no latency edge
  task automatic run_stream(input int len, input int adj_at, input int zeros_exp,
                            input int pfull_at);
    int                               rd_lag;
    int                               wr_cnt, rd_cnt;      // Pushes and pops so far
    int                               wr_seen1, wr_seen2;  // Push count through read sync
    int                               rd_seen1, rd_seen2;  // Pop count through write sync
    int                               wr_lvl, rd_lvl;      // Occupancy seen per domain
    bit                               traffic, wr_pred, rd_pred, adj_beat;
    bit                               full_pred, pfull_pred, empty_pred, pempty_pred;
    logic [txdp_pkg::txdp_dwidth-1:0] direct_w, lo_w, hi_w, exp_w;
    rd_lag = (r_phcomp_rd_delay >= 3 && r_phcomp_rd_delay <= txdp_pkg::txdp_rd_delay_max) ?
             int'(r_phcomp_rd_delay) : 2;
    traffic = (r_fifo_mode == txdp_pkg::mode_phcomp_1x) ||
              (r_fifo_mode == txdp_pkg::mode_phcomp_2x);
    words_seen = 0;
    zero_beats = 0;
    wr_cnt = 0;
    rd_cnt = 0;
    wr_seen1 = 0;
    wr_seen2 = 0;
    rd_seen1 = 0;
    rd_seen2 = 0;
    for (int n = 0; n < len; n++) begin
      adj_beat = adj_at >= 0 && n == adj_at + 2;  // Edge pulse after two sync flops
      wr_pred = traffic && n >= 3 && !(r_wr_adj_en && adj_beat);
      rd_pred = traffic && n >= 3 + rd_lag && !(r_rd_adj_en && adj_beat);
      wr_lvl = wr_cnt - rd_seen2;
      rd_lvl = wr_seen2 - rd_cnt;
      full_pred = wr_lvl >= int'(r_full[txdp_pkg::txdp_fifo_awidth-1:0]);
      pfull_pred = wr_lvl >= int'(r_pfull[txdp_pkg::txdp_fifo_awidth-1:0]);
      empty_pred = rd_lvl <= int'(r_empty[txdp_pkg::txdp_fifo_awidth-1:0]);
      pempty_pred = rd_lvl <= int'(r_pempty[txdp_pkg::txdp_fifo_awidth-1:0]);
      if (n == 1) check_reset_state();
      check_value(fifo_full == full_pred && fifo_pfull == pfull_pred,
                  "write side flags mismatch");
      check_value(fifo_empty == empty_pred && fifo_pempty == pempty_pred,
                  "read side flags mismatch");
      check_value(tx_fifo_testbus1 == {16'd0, full_pred, pfull_pred,
                                       wr_cnt[txdp_pkg::txdp_fifo_awidth-1], wr_pred},
                  "testbus1 mismatch");
      check_value(tx_fifo_testbus2 == {16'd0, empty_pred, pempty_pred,
                                       rd_cnt[txdp_pkg::txdp_fifo_awidth-1], rd_pred},
                  "testbus2 mismatch");
      check_value(fifo_ready == (r_fifo_mode == txdp_pkg::mode_register), "fifo_ready wrong");
      if (!traffic) check_value(data_out == '0 && fifo_empty, "data moved in idle mode");
      if (pfull_at > 0) check_value(fifo_pfull == (n >= pfull_at), "fifo_pfull mismatch");
      if (data_out != '0) begin
        exp_w = (ref_q.size() > 0) ? ref_q.pop_front() : '0;
        check_value(data_out == exp_w, "output word out of order");
        words_seen++;
      end else if (words_seen > 0) begin
        zero_beats++;  // Gap inside the stream
      end
      next_word(direct_w);
      next_word(lo_w);
      next_word(hi_w);
      direct_data = direct_w;
      data_in = {hi_w, lo_w};
      fifo_latency_adj = adj_at >= 0 && n >= adj_at;
      if (wr_pred) ref_q.push_back(r_fifo_mode == txdp_pkg::mode_phcomp_1x ? direct_w : lo_w);
      wr_seen2 = wr_seen1;  // Two flops per crossing
      wr_seen1 = wr_cnt;
      rd_seen2 = rd_seen1;
      rd_seen1 = rd_cnt;
      if (wr_pred) wr_cnt++;
      if (rd_pred && rd_lvl > 0) rd_cnt++;  // No pop when empty
      @(posedge clk);
      #0.5;
    end
    check_value(zero_beats == zeros_exp, "wrong number of idle beats in the stream");
    if (traffic) check_value(words_seen >= len - 16, "too few words reached the output");
  endtask

  task automatic report_test(input string name);
    int fails;
    fails = error_count + uut.u_ctrl.u_asserts.fail_count - errors_marked;
    $display("test %-16s done, %0d failures", name, fails);
    errors_marked += fails;
    test_count++;
  endtask

  //**********************************************************************
  // Test sequence
  //**********************************************************************

  initial begin
    lfsr = 32'h5744_9817;
    rst_n = 1'b0;
    data_in = '0;
    direct_data = '0;
    r_empty = 5'd0;
    r_pempty = 5'd1;
    r_full = 5'd15;    // Above any gap used here
    r_pfull = 5'd12;
    r_fifo_mode = txdp_pkg::mode_register;
    r_phcomp_rd_delay = 3'd0;
    r_wr_adj_en = 1'b0;
    r_rd_adj_en = 1'b0;
    fifo_latency_adj = 1'b0;

    for (int code = 0; code < 8; code++) begin  // Every delay code, no traffic
      apply_reset(code[0] ? txdp_pkg::mode_reserved : txdp_pkg::mode_register,
                  code[2:0], 1'b0, 1'b0, 5'd12);
      run_stream(16, -1, 0, 0);
      check_value(phcomp_wren && phcomp_rden, "enables not high after the ramp");
    end
    report_test("enable_ramp");

    apply_reset(txdp_pkg::mode_phcomp_1x, 3'd4, 1'b0, 1'b0, 5'd12);
    run_stream(48, -1, 0, 0);
    report_test("order_1x");

    apply_reset(txdp_pkg::mode_phcomp_2x, 3'd6, 1'b0, 1'b0, 5'd2);
    run_stream(48, -1, 0, 5);  // Write level reaches 2 on the fifth edge
    report_test("order_2x_pfull");

    apply_reset(txdp_pkg::mode_phcomp_1x, 3'd4, 1'b1, 1'b0, 5'd12);
    run_stream(48, 12, 0, 0);
    report_test("wr_adjust");

    apply_reset(txdp_pkg::mode_phcomp_2x, 3'd4, 1'b0, 1'b1, 5'd12);
    run_stream(48, 12, 1, 0);
    report_test("rd_adjust");

    $display("tests %0d, checks %0d, failed checks %0d, failed assertions %0d",
             test_count, check_count, error_count, uut.u_ctrl.u_asserts.fail_count);
    if (error_count == 0 && uut.u_ctrl.u_asserts.fail_count == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== flist.f ====
src/txdp_pkg.sv
src/txdp_bitsync.sv
src/txdp_async_fifo.sv
src/txdp_phcomp_ctrl.sv
src/txdp_out_reg.sv
src/aib_adapttxdp_fifo.sv
bench/txdp_asserts.sv
bench/tb_txdp.sv
